// File: vlog.f
hdl/dispatch_pkg.sv
hdl/instr_pkg.sv
hdl/cluster_ifs.sv
hdl/threads_manager.sv
hdl/dispatcher_of_cpus.sv
hdl/cpu_slot.sv
hdl/mem_arbiter.sv
hdl/cpu_cluster.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_cpu_cluster.sv

// File: test/tb_cpu_cluster.sv
module tb_cpu_cluster;

  localparam int NUM_ROWS = 4;
  localparam int MAX_ST = 6;
  localparam int MEM_WORDS = 256;

  logic clk;
  logic ext_rst_e;
  logic start;
  logic [dispatch_pkg::ADDR_W-1:0] start_addr;
  logic ext_read_dn;
  logic ext_write_dn;
  logic [dispatch_pkg::DATA_W-1:0] ext_mem_rdata;
  logic ext_read_q;
  logic ext_write_q;
  logic [dispatch_pkg::ADDR_W-1:0] ext_mem_addr;
  logic [dispatch_pkg::DATA_W-1:0] ext_mem_wdata;
  logic idle;

  // word addressed memory behind the external port
  logic [dispatch_pkg::DATA_W-1:0] mem [MEM_WORDS];

  // one row per test, start address and expected stores
  logic [dispatch_pkg::ADDR_W-1:0] row_start [NUM_ROWS];
  logic [dispatch_pkg::ADDR_W-1:0] row_addr [NUM_ROWS][MAX_ST];
  logic [dispatch_pkg::DATA_W-1:0] row_data [NUM_ROWS][MAX_ST];
  int row_count [NUM_ROWS];

  logic ok;
  int timeouts;
  int r;
  int k;
  int seed;
  int lat;
  int mem_wait;
  int mem_phase;

  tb_clock clock_i (
    .clk (clk)
  );

  cpu_cluster cpu_cluster_i (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .start         (start),
    .start_addr    (start_addr),
    .ext_read_dn   (ext_read_dn),
    .ext_write_dn  (ext_write_dn),
    .ext_mem_rdata (ext_mem_rdata),
    .ext_read_q    (ext_read_q),
    .ext_write_q   (ext_write_q),
    .ext_mem_addr  (ext_mem_addr),
    .ext_mem_wdata (ext_mem_wdata),
    .idle          (idle)
  );

  tb_checker checker_i (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .ext_read_q    (ext_read_q),
    .ext_read_dn   (ext_read_dn),
    .ext_write_q   (ext_write_q),
    .ext_write_dn  (ext_write_dn),
    .ext_mem_addr  (ext_mem_addr),
    .ext_mem_wdata (ext_mem_wdata),
    .idle          (idle)
  );

  // load / store word: opcode, 12 reserved bits, address
  function automatic logic [31:0] mem_word(input logic [3:0] op, input logic [15:0] addr);
    return {op, 12'h000, addr};
  endfunction

  // addi / fork / end word: opcode and 28 bit value
  function automatic logic [31:0] ctl_word(input logic [3:0] op, input logic [27:0] value);
    return {op, value};
  endfunction

  task automatic load_programs();
    int a;
    int c;
    // fill word has unknown opcode 0xf, so it ends a thread
    for (a = 0; a < MEM_WORDS; a++) begin
      mem[a] = {4'hF, 20'h0_0000, 8'(a)};
    end
    mem[8'h80] = 32'h1234_5670;
    mem[8'h81] = 32'h0000_0001;
    // single thread, load plus positive immediate
    mem[8'h10] = mem_word(instr_pkg::OP_LD, 16'h0080);
    mem[8'h11] = ctl_word(instr_pkg::OP_ADDI, 28'h000_0025);
    mem[8'h12] = mem_word(instr_pkg::OP_ST, 16'h0090);
    mem[8'h13] = ctl_word(instr_pkg::OP_END, 28'h0);
    // negative immediate, runs into the fill word
    mem[8'h18] = mem_word(instr_pkg::OP_LD, 16'h0081);
    mem[8'h19] = ctl_word(instr_pkg::OP_ADDI, 28'hFFF_FFFD);
    mem[8'h1A] = mem_word(instr_pkg::OP_ST, 16'h0091);
    // parent with three children at 0x40, 0x44, 0x48
    for (c = 0; c < 3; c++) begin
      mem[8'h20 + c] = ctl_word(instr_pkg::OP_FORK, 28'(32'h40 + 4 * c));
      mem[8'h40 + 4 * c] = ctl_word(instr_pkg::OP_ADDI, 28'(32'h100 + c));
      mem[8'h41 + 4 * c] = mem_word(instr_pkg::OP_ST, 16'(32'hA0 + c));
      mem[8'h42 + 4 * c] = ctl_word(instr_pkg::OP_END, 28'h0);
    end
    mem[8'h23] = ctl_word(instr_pkg::OP_END, 28'h0);
    // parent with six children from 0x50, more than the slots
    for (c = 0; c < 6; c++) begin
      mem[8'h30 + c] = ctl_word(instr_pkg::OP_FORK, 28'(32'h50 + 4 * c));
      mem[8'h50 + 4 * c] = ctl_word(instr_pkg::OP_ADDI, 28'(32'h200 + c));
      mem[8'h51 + 4 * c] = mem_word(instr_pkg::OP_ST, 16'(32'hB0 + c));
      mem[8'h52 + 4 * c] = ctl_word(instr_pkg::OP_END, 28'h0);
    end
    mem[8'h36] = ctl_word(instr_pkg::OP_END, 28'h0);
  endtask

  task automatic build_table();
    int c;
    // 0x12345670 + 0x25
    row_start[0] = 16'h0010;
    row_count[0] = 1;
    row_addr[0][0] = 16'h0090;
    row_data[0][0] = 32'h1234_5695;
    // 1 + (-3), sign extended to the full word
    row_start[1] = 16'h0018;
    row_count[1] = 1;
    row_addr[1][0] = 16'h0091;
    row_data[1][0] = 32'hFFFF_FFFE;
    // children start from a cleared accumulator
    row_start[2] = 16'h0020;
    row_count[2] = 3;
    row_start[3] = 16'h0030;
    row_count[3] = 6;
    for (c = 0; c < 3; c++) begin
      row_addr[2][c] = 16'(32'hA0 + c);
      row_data[2][c] = 32'h100 + c;
    end
    for (c = 0; c < 6; c++) begin
      row_addr[3][c] = 16'(32'hB0 + c);
      row_data[3][c] = 32'h200 + c;
    end
  endtask

  // poll idle on each edge, give up after limit cycles
  task automatic wait_idle(input int limit, input int row, output logic done);
    int n;
    done = 1'b0;
    n = 0;
    while (!done && n < limit) begin
      @(posedge clk);
      if (idle) begin
        done = 1'b1;
      end
      n++;
    end
    if (!done) begin
      timeouts++;
      $display("row %0d: idle did not come back within %0d cycles", row, limit);
    end
  endtask

  // answer the request seen on this edge
  task automatic answer_request();
    if (ext_write_q) begin
      mem[ext_mem_addr[7:0]] = ext_mem_wdata;
      ext_write_dn <= 1'b1;
    end else begin
      ext_mem_rdata <= mem[ext_mem_addr[7:0]];
      ext_read_dn <= 1'b1;
    end
  endtask

  // memory model, 0 to 5 cycles of random latency
  initial begin
    seed = 12;
    lat = $urandom(seed);
    ext_read_dn = 1'b0;
    ext_write_dn = 1'b0;
    ext_mem_rdata = '0;
    mem_phase = 0;
    mem_wait = 0;
    forever begin
      @(posedge clk);
      if (ext_rst_e) begin
        ext_read_dn <= 1'b0;
        ext_write_dn <= 1'b0;
        mem_phase = 0;
      end else begin
        case (mem_phase)
          0: begin
            if (ext_read_q || ext_write_q) begin
              lat = $urandom % 6;
              if (lat == 0) begin
                answer_request();
                mem_phase = 2;
              end else begin
                mem_wait = lat - 1;
                mem_phase = 1;
              end
            end
          end
          1: begin
            if (mem_wait == 0) begin
              answer_request();
              mem_phase = 2;
            end else begin
              mem_wait = mem_wait - 1;
            end
          end
          // done is a single cycle pulse
          2: begin
            ext_read_dn <= 1'b0;
            ext_write_dn <= 1'b0;
            mem_phase = 3;
          end
          // strobe must drop before the next request
          default: begin
            if (!ext_read_q && !ext_write_q) begin
              mem_phase = 0;
            end
          end
        endcase
      end
    end
  end

  initial begin
    ok = 1'b1;
    timeouts = 0;
    ext_rst_e = 1'b1;
    start = 1'b0;
    start_addr = '0;
    load_programs();
    build_table();
    repeat (3) @(posedge clk);
    ext_rst_e <= 1'b0;
    // quiet before the first start
    repeat (2) begin
      @(posedge clk);
      checker_i.check_quiet();
    end
    for (r = 0; r < NUM_ROWS && ok; r++) begin
      wait_idle(100, r, ok);
      if (ok) begin
        checker_i.clear_stores();
        for (k = 0; k < row_count[r]; k++) begin
          checker_i.expect_store(row_addr[r][k], row_data[r][k]);
        end
        start <= 1'b1;
        start_addr <= row_start[r];
        @(posedge clk);
        start <= 1'b0;
        wait_idle(3000, r, ok);
        if (ok) begin
          checker_i.compare_stores(r);
        end
      end
    end
    $display("errors: %0d from checks, %0d timeouts", checker_i.err_count, timeouts);
    if (checker_i.err_count == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: test/tb_checker.sv
module tb_checker (
  input logic clk,
  input logic ext_rst_e,
  input logic ext_read_q,
  input logic ext_read_dn,
  input logic ext_write_q,
  input logic ext_write_dn,
  input logic [dispatch_pkg::ADDR_W-1:0] ext_mem_addr,
  input logic [dispatch_pkg::DATA_W-1:0] ext_mem_wdata,
  input logic idle
);

  int err_count = 0;

  // stores seen on the external port since the last clear
  logic [dispatch_pkg::ADDR_W-1:0] seen_addr [$];
  logic [dispatch_pkg::DATA_W-1:0] seen_data [$];
  // stores the current row expects
  logic [dispatch_pkg::ADDR_W-1:0] exp_addr [$];
  logic [dispatch_pkg::DATA_W-1:0] exp_data [$];

  // request from the previous cycle that must still be held
  logic hold_v;
  logic hold_rd;
  logic hold_wr;
  logic [dispatch_pkg::ADDR_W-1:0] hold_addr;
  logic [dispatch_pkg::DATA_W-1:0] hold_wdata;

  // capture each completed write once
  always @(posedge clk) begin
    if (!ext_rst_e && ext_write_q && ext_write_dn) begin
      seen_addr.push_back(ext_mem_addr);
      seen_data.push_back(ext_mem_wdata);
    end
  end

  // strobe, address and write data frozen until done
  always @(posedge clk) begin
    if (ext_rst_e) begin
      hold_v <= 1'b0;
    end else begin
      if (hold_v) begin
        if (ext_read_q !== hold_rd) begin
          err_count++;
          $display("[ERROR] ext_read_q changed before done: 0x%h -> 0x%h", hold_rd, ext_read_q);
        end
        if (ext_write_q !== hold_wr) begin
          err_count++;
          $display("[ERROR] ext_write_q changed before done: 0x%h -> 0x%h",
                   hold_wr, ext_write_q);
        end
        if (ext_mem_addr !== hold_addr) begin
          err_count++;
          $display("[ERROR] ext_mem_addr changed before done: 0x%h -> 0x%h",
                   hold_addr, ext_mem_addr);
        end
        if (hold_wr && ext_mem_wdata !== hold_wdata) begin
          err_count++;
          $display("[ERROR] ext_mem_wdata changed before done: 0x%h -> 0x%h",
                   hold_wdata, ext_mem_wdata);
        end
      end
      // open request with no done this cycle
      hold_v <= (ext_read_q && !ext_read_dn) || (ext_write_q && !ext_write_dn);
      hold_rd <= ext_read_q;
      hold_wr <= ext_write_q;
      hold_addr <= ext_mem_addr;
      hold_wdata <= ext_mem_wdata;
    end
  end

  // quiet state after reset
  task automatic check_quiet();
    if (idle !== 1'b1) begin
      err_count++;
      $display("[ERROR] idle after reset is 0x%h, expected 0x1", idle);
    end
    if (ext_read_q !== 1'b0) begin
      err_count++;
      $display("[ERROR] ext_read_q after reset is 0x%h, expected 0x0", ext_read_q);
    end
    if (ext_write_q !== 1'b0) begin
      err_count++;
      $display("[ERROR] ext_write_q after reset is 0x%h, expected 0x0", ext_write_q);
    end
  endtask

  task automatic clear_stores();
    seen_addr.delete();
    seen_data.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic expect_store(input logic [dispatch_pkg::ADDR_W-1:0] addr,
                              input logic [dispatch_pkg::DATA_W-1:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // unordered match, each expected store exactly once
  task automatic compare_stores(input int row);
    int i;
    int j;
    bit found;
    for (i = 0; i < exp_addr.size(); i++) begin
      found = 1'b0;
      j = 0;
      while (!found && j < seen_addr.size()) begin
        if (seen_addr[j] == exp_addr[i]) begin
          found = 1'b1;
        end else begin
          j++;
        end
      end
      if (!found) begin
        err_count++;
        $display("row %0d: no store to address 0x%h was seen", row, exp_addr[i]);
      end else begin
        if (seen_data[j] !== exp_data[i]) begin
          err_count++;
          $display("[ERROR] row %0d ext_mem_wdata at 0x%h: got 0x%h, expected 0x%h",
                   row, exp_addr[i], seen_data[j], exp_data[i]);
        end
        seen_addr.delete(j);
        seen_data.delete(j);
      end
    end
    // leftovers are extra or repeated stores
    for (i = 0; i < seen_addr.size(); i++) begin
      err_count++;
      $display("row %0d: unexpected store of 0x%h to address 0x%h",
               row, seen_data[i], seen_addr[i]);
    end
    clear_stores();
  endtask

endmodule

// File: test/tb_clock.sv
module tb_clock (
  output logic clk
);

  // free running clock, 8 unit period
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

endmodule

// File: hdl/cpu_cluster.sv
module cpu_cluster (
  input  logic clk,
  input  logic ext_rst_e,
  input  logic start,
  input  logic [dispatch_pkg::ADDR_W-1:0] start_addr,
  input  logic ext_read_dn,
  input  logic ext_write_dn,
  input  logic [dispatch_pkg::DATA_W-1:0] ext_mem_rdata,
  output logic ext_read_q,
  output logic ext_write_q,
  output logic [dispatch_pkg::ADDR_W-1:0] ext_mem_addr,
  output logic [dispatch_pkg::DATA_W-1:0] ext_mem_wdata,
  output logic idle
);

  logic busy;
  logic pending;

  // per slot links
  dispatch_if disp_link [dispatch_pkg::NUM_SLOTS] ();
  mem_req_if mem_link [dispatch_pkg::NUM_SLOTS] ();

  dispatcher_of_cpus dispatcher_i (
    .clk        (clk),
    .ext_rst_e  (ext_rst_e),
    .start      (start),
    .start_addr (start_addr),
    .slots      (disp_link),
    .busy       (busy)
  );

  for (genvar i = 0; i < dispatch_pkg::NUM_SLOTS; i++) begin : g_slot
    cpu_slot cpu_slot_i (
      .clk       (clk),
      .ext_rst_e (ext_rst_e),
      .disp      (disp_link[i]),
      .mem       (mem_link[i])
    );
  end

  mem_arbiter mem_arbiter_i (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .reqs          (mem_link),
    .ext_read_q    (ext_read_q),
    .ext_write_q   (ext_write_q),
    .ext_mem_addr  (ext_mem_addr),
    .ext_mem_wdata (ext_mem_wdata),
    .ext_read_dn   (ext_read_dn),
    .ext_write_dn  (ext_write_dn),
    .ext_mem_rdata (ext_mem_rdata),
    .pending       (pending)
  );

  // nothing queued, running or waiting on memory
  assign idle = !busy && !pending;

endmodule

// File: hdl/mem_arbiter.sv
module mem_arbiter (
  input  logic clk,
  input  logic ext_rst_e,
  mem_req_if.arb reqs [dispatch_pkg::NUM_SLOTS],
  output logic ext_read_q,
  output logic ext_write_q,
  output logic [dispatch_pkg::ADDR_W-1:0] ext_mem_addr,
  output logic [dispatch_pkg::DATA_W-1:0] ext_mem_wdata,
  input  logic ext_read_dn,
  input  logic ext_write_dn,
  input  logic [dispatch_pkg::DATA_W-1:0] ext_mem_rdata,
  output logic pending
);

  localparam int N = dispatch_pkg::NUM_SLOTS;

  // request wires per slot
  logic [N-1:0] req_v;
  logic [N-1:0] req_w;
  logic [dispatch_pkg::ADDR_W-1:0] req_a [N];
  logic [dispatch_pkg::DATA_W-1:0] req_d [N];

  // one parked request per slot
  logic [N-1:0] req_pend;
  logic [N-1:0] buf_write;
  logic [dispatch_pkg::ADDR_W-1:0] buf_addr [N];
  logic [dispatch_pkg::DATA_W-1:0] buf_wdata [N];

  logic [dispatch_pkg::SLOT_W-1:0] rr_ptr;
  logic [dispatch_pkg::SLOT_W-1:0] gnt_sel;
  logic [dispatch_pkg::SLOT_W-1:0] gnt_idx;
  logic gnt_v;
  logic ext_on;
  logic ext_done;
  logic [N-1:0] rsp_credit_r;
  logic [dispatch_pkg::DATA_W-1:0] rsp_rdata_r;

  for (genvar i = 0; i < N; i++) begin : g_req_io
    assign req_v[i] = reqs[i].req_valid;
    assign req_w[i] = reqs[i].req_write;
    assign req_a[i] = reqs[i].req_addr;
    assign req_d[i] = reqs[i].req_wdata;
    assign reqs[i].rsp_credit = rsp_credit_r[i];
    // only the credited slot looks at the data
    assign reqs[i].rsp_rdata = rsp_rdata_r;
  end

  assign gnt_sel = dispatch_pkg::rr_pick(req_pend, rr_ptr);
  assign ext_on = ext_read_q || ext_write_q;
  // done only counts for the side that is requesting
  assign ext_done = (ext_read_q && ext_read_dn) || (ext_write_q && ext_write_dn);
  assign pending = (|req_pend) || gnt_v;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      req_pend <= '0;
      rr_ptr <= '0;
      gnt_idx <= '0;
      gnt_v <= 1'b0;
      ext_read_q <= 1'b0;
      ext_write_q <= 1'b0;
      rsp_credit_r <= '0;
    end else begin
      rsp_credit_r <= '0;
      req_pend <= req_pend | req_v;
      if (!gnt_v && (|req_pend)) begin
        // grant, strobe goes up next cycle
        gnt_v <= 1'b1;
        gnt_idx <= gnt_sel;
        rr_ptr <= gnt_sel + 1'b1;
        req_pend <= (req_pend | req_v) & ~(N'(1) << gnt_sel);
      end else if (gnt_v && !ext_on) begin
        ext_read_q <= !buf_write[gnt_idx];
        ext_write_q <= buf_write[gnt_idx];
      end else if (ext_done) begin
        // strobe drops, credit back to slot a cycle later
        ext_read_q <= 1'b0;
        ext_write_q <= 1'b0;
        gnt_v <= 1'b0;
        rsp_credit_r[gnt_idx] <= 1'b1;
      end
    end
  end

  // request payload and external bus data
  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (req_v[i]) begin
        buf_write[i] <= req_w[i];
        buf_addr[i] <= req_a[i];
        buf_wdata[i] <= req_d[i];
      end
    end
    // held steady while the strobe is up
    if (gnt_v && !ext_on) begin
      ext_mem_addr <= buf_addr[gnt_idx];
      ext_mem_wdata <= buf_wdata[gnt_idx];
    end
    if (ext_read_q && ext_read_dn) begin
      rsp_rdata_r <= ext_mem_rdata;
    end
  end

endmodule

// File: hdl/cpu_slot.sv
module cpu_slot (
  input logic clk,
  input logic ext_rst_e,
  dispatch_if.slot disp,
  mem_req_if.master mem
);

  logic [instr_pkg::ST_W-1:0] state;
  logic [dispatch_pkg::ADDR_W-1:0] pc;
  logic [dispatch_pkg::DATA_W-1:0] acc;
  // last fetched word
  instr_pkg::instr_t ir;

  // one memory request and one fork in flight at most
  logic mem_cred;
  logic fork_cred;

  logic is_store;
  logic is_addi;
  logic [dispatch_pkg::DATA_W-1:0] imm_ext;

  // store vs load seen through the memory form
  assign is_store = (ir.m.opcode == instr_pkg::OP_ST);
  assign is_addi = (ir.c.opcode == instr_pkg::OP_ADDI);
  // sign extend 28 bit immediate
  assign imm_ext = {{(dispatch_pkg::DATA_W - instr_pkg::VAL_W){ir.c.value[instr_pkg::VAL_W-1]}},
                    ir.c.value};

  // request goes out while the credit is still here
  assign mem.req_valid = mem_cred &&
                         (state == instr_pkg::ST_FETCH || state == instr_pkg::ST_DATA);
  assign mem.req_write = (state == instr_pkg::ST_DATA) && is_store;
  assign mem.req_addr = (state == instr_pkg::ST_DATA) ? ir.m.addr : pc;
  assign mem.req_wdata = acc;

  // child address in low bits of value
  assign disp.fork_valid = (state == instr_pkg::ST_FORK) && fork_cred;
  assign disp.fork_msg.addr = ir.c.value[dispatch_pkg::ADDR_W-1:0];
  // single cycle in end state
  assign disp.done_credit = (state == instr_pkg::ST_END);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state <= instr_pkg::ST_WAIT;
      mem_cred <= 1'b1;
      fork_cred <= 1'b1;
    end else begin
      // credits spent on send, back on response
      mem_cred <= (mem_cred & ~mem.req_valid) | mem.rsp_credit;
      fork_cred <= (fork_cred & ~disp.fork_valid) | disp.fork_credit;
      case (state)
        instr_pkg::ST_WAIT: begin
          if (disp.disp_valid) begin
            state <= instr_pkg::ST_FETCH;
          end
        end
        instr_pkg::ST_FETCH: begin
          if (mem.rsp_credit) begin
            state <= instr_pkg::ST_DECODE;
          end
        end
        instr_pkg::ST_DECODE: begin
          case (ir.c.opcode)
            instr_pkg::OP_LD, instr_pkg::OP_ST: state <= instr_pkg::ST_DATA;
            instr_pkg::OP_ADDI: state <= instr_pkg::ST_FETCH;
            instr_pkg::OP_FORK: state <= instr_pkg::ST_FORK;
            // unknown opcodes end the thread too
            default: state <= instr_pkg::ST_END;
          endcase
        end
        instr_pkg::ST_DATA: begin
          if (mem.rsp_credit) begin
            state <= instr_pkg::ST_FETCH;
          end
        end
        instr_pkg::ST_FORK: begin
          // stall here without a fork credit
          if (fork_cred) begin
            state <= instr_pkg::ST_FETCH;
          end
        end
        default: state <= instr_pkg::ST_WAIT;
      endcase
    end
  end

  // pc, accumulator, instruction register
  always_ff @(posedge clk) begin
    if (state == instr_pkg::ST_WAIT && disp.disp_valid) begin
      pc <= disp.disp_addr;
      acc <= '0;
    end
    if (state == instr_pkg::ST_FETCH && mem.rsp_credit) begin
      ir <= mem.rsp_rdata;
    end
    if (state == instr_pkg::ST_DECODE && is_addi) begin
      acc <= acc + imm_ext;
      pc <= pc + 1'b1;
    end
    if (state == instr_pkg::ST_DATA && mem.rsp_credit) begin
      if (!is_store) begin
        acc <= mem.rsp_rdata;
      end
      pc <= pc + 1'b1;
    end
    if (state == instr_pkg::ST_FORK && fork_cred) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

// File: hdl/dispatcher_of_cpus.sv
module dispatcher_of_cpus (
  input  logic clk,
  input  logic ext_rst_e,
  input  logic start,
  input  logic [dispatch_pkg::ADDR_W-1:0] start_addr,
  dispatch_if.disp slots [dispatch_pkg::NUM_SLOTS],
  output logic busy
);

  localparam int N = dispatch_pkg::NUM_SLOTS;

  // per slot view of the interface array
  logic [N-1:0] done_v;
  logic [N-1:0] fork_v;
  logic [dispatch_pkg::ADDR_W-1:0] fork_a [N];

  // dispatch credits, set bit means slot is free
  logic [N-1:0] credit;
  logic [N-1:0] disp_valid_r;
  logic [dispatch_pkg::ADDR_W-1:0] disp_addr_r;
  logic [dispatch_pkg::SLOT_W-1:0] disp_rr;
  logic [dispatch_pkg::SLOT_W-1:0] disp_sel;
  logic [N-1:0] disp_oh;

  // forks held here until the queue has room
  logic [N-1:0] fork_pend;
  logic [dispatch_pkg::ADDR_W-1:0] fork_buf [N];
  logic [N-1:0] fork_cand;
  logic [N-1:0] fork_cr_r;
  logic [dispatch_pkg::SLOT_W-1:0] fork_rr;
  logic [dispatch_pkg::SLOT_W-1:0] fork_sel;
  logic [N-1:0] fork_oh;
  logic take_fork;

  // start request, held until pushed
  logic start_pend;
  logic [dispatch_pkg::ADDR_W-1:0] start_buf;
  logic take_start;

  // run queue side
  logic push;
  logic [dispatch_pkg::ADDR_W-1:0] push_addr;
  logic pop;
  logic [dispatch_pkg::ADDR_W-1:0] head_addr;
  logic empty;
  logic full;

  threads_manager runq_i (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .push      (push),
    .push_addr (push_addr),
    .pop       (pop),
    .head_addr (head_addr),
    .empty     (empty),
    .full      (full)
  );

  for (genvar i = 0; i < N; i++) begin : g_slot_io
    assign done_v[i] = slots[i].done_credit;
    assign fork_v[i] = slots[i].fork_valid;
    assign fork_a[i] = slots[i].fork_msg.addr;
    assign slots[i].disp_valid = disp_valid_r[i];
    // one dispatch per cycle, address can be shared
    assign slots[i].disp_addr = disp_addr_r;
    assign slots[i].fork_credit = fork_cr_r[i];
  end

  // dispatch head of queue to next free slot
  assign disp_sel = dispatch_pkg::rr_pick(credit, disp_rr);
  assign disp_oh = N'(1) << disp_sel;
  assign pop = !empty && (|credit);

  // fork taken straight off the wire or from its buffer
  assign fork_cand = fork_pend | fork_v;
  assign fork_sel = dispatch_pkg::rr_pick(fork_cand, fork_rr);
  assign fork_oh = N'(1) << fork_sel;
  assign take_fork = (|fork_cand) && !full;
  // start only when no fork wants the slot this cycle
  assign take_start = !take_fork && start_pend && !full;

  assign push = take_fork || take_start;
  assign push_addr = take_fork ? (fork_pend[fork_sel] ? fork_buf[fork_sel] : fork_a[fork_sel])
                               : start_buf;

  // queued work, a running slot, or anything not yet queued
  assign busy = !empty || start_pend || (|fork_pend) || !(&credit);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      credit <= '1;
      disp_valid_r <= '0;
      disp_rr <= '0;
      fork_pend <= '0;
      fork_cr_r <= '0;
      fork_rr <= '0;
      start_pend <= 1'b0;
    end else begin
      // returned credits in, dispatched credit out
      credit <= (credit | done_v) & ~(pop ? disp_oh : '0);
      disp_valid_r <= pop ? disp_oh : '0;
      if (pop) begin
        disp_rr <= disp_sel + 1'b1;
      end
      // new forks park, taken one leaves
      fork_pend <= (fork_pend | fork_v) & ~(take_fork ? fork_oh : '0);
      fork_cr_r <= take_fork ? fork_oh : '0;
      if (take_fork) begin
        fork_rr <= fork_sel + 1'b1;
      end
      if (start && !start_pend) begin
        start_pend <= 1'b1;
      end else if (take_start) begin
        start_pend <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (pop) begin
      disp_addr_r <= head_addr;
    end
    if (start && !start_pend) begin
      start_buf <= start_addr;
    end
    for (int i = 0; i < N; i++) begin
      if (fork_v[i]) begin
        fork_buf[i] <= fork_a[i];
      end
    end
  end

endmodule

// File: hdl/threads_manager.sv
module threads_manager (
  input  logic clk,
  input  logic ext_rst_e,
  input  logic push,
  input  logic [dispatch_pkg::ADDR_W-1:0] push_addr,
  input  logic pop,
  output logic [dispatch_pkg::ADDR_W-1:0] head_addr,
  output logic empty,
  output logic full
);

  // storage of pending thread start addresses
  logic [dispatch_pkg::ADDR_W-1:0] thrd_mem [dispatch_pkg::RUNQ_DEPTH];

  // pointers wrap on their own, depth is a power of two
  logic [dispatch_pkg::RUNQ_AW-1:0] wr_ptr;
  logic [dispatch_pkg::RUNQ_AW-1:0] rd_ptr;
  logic [dispatch_pkg::RUNQ_AW:0] count;

  logic push_ok;
  logic pop_ok;

  assign empty = (count == '0);
  assign full = (count == (dispatch_pkg::RUNQ_AW + 1)'(dispatch_pkg::RUNQ_DEPTH));

  // guard against overflow / underflow
  assign push_ok = push && !full;
  assign pop_ok = pop && !empty;

  // oldest entry always visible
  assign head_addr = thrd_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push_ok, pop_ok})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry write
  always_ff @(posedge clk) begin
    if (push_ok) begin
      thrd_mem[wr_ptr] <= push_addr;
    end
  end

endmodule

// File: hdl/cluster_ifs.sv
// dispatcher <-> slot, one instance per slot
interface dispatch_if;
  logic disp_valid;
  logic [dispatch_pkg::ADDR_W-1:0] disp_addr;
  // pulse on thread end, gives the slot back
  logic done_credit;
  logic fork_valid;
  dispatch_pkg::fork_msg_t fork_msg;
  // pulse once a fork is taken into the run queue
  logic fork_credit;

  modport disp (output disp_valid, disp_addr, fork_credit,
                input done_credit, fork_valid, fork_msg);
  modport slot (input disp_valid, disp_addr, fork_credit,
                output done_credit, fork_valid, fork_msg);
endinterface

// slot -> memory arbiter, one outstanding request
interface mem_req_if;
  logic req_valid;
  logic req_write;
  logic [dispatch_pkg::ADDR_W-1:0] req_addr;
  logic [dispatch_pkg::DATA_W-1:0] req_wdata;
  // pulse with the response, returns the request credit
  logic rsp_credit;
  logic [dispatch_pkg::DATA_W-1:0] rsp_rdata;

  modport master (output req_valid, req_write, req_addr, req_wdata,
                  input rsp_credit, rsp_rdata);
  modport arb (input req_valid, req_write, req_addr, req_wdata,
               output rsp_credit, rsp_rdata);
endinterface

// File: hdl/instr_pkg.sv
package instr_pkg;

  // field widths of an instruction word
  localparam int OPC_W = 4;
  localparam int RSV_W = 12;
  localparam int VAL_W = 28;

  // opcodes, anything not listed acts as end
  localparam logic [OPC_W-1:0] OP_END = 4'h0;
  localparam logic [OPC_W-1:0] OP_LD = 4'h1;
  localparam logic [OPC_W-1:0] OP_ADDI = 4'h2;
  localparam logic [OPC_W-1:0] OP_ST = 4'h3;
  localparam logic [OPC_W-1:0] OP_FORK = 4'h4;

  // slot execution states
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_WAIT = 3'd0;
  localparam logic [ST_W-1:0] ST_FETCH = 3'd1;
  localparam logic [ST_W-1:0] ST_DECODE = 3'd2;
  localparam logic [ST_W-1:0] ST_DATA = 3'd3;
  localparam logic [ST_W-1:0] ST_FORK = 3'd4;
  localparam logic [ST_W-1:0] ST_END = 3'd5;

  // load / store form
  typedef struct packed {
    logic [OPC_W-1:0] opcode;
    logic [RSV_W-1:0] rsvd;
    logic [dispatch_pkg::ADDR_W-1:0] addr;
  } mem_form_t;

  // addi / fork form, value is immediate or child address
  typedef struct packed {
    logic [OPC_W-1:0] opcode;
    logic [VAL_W-1:0] value;
  } ctl_form_t;

  // one fetched word, read through either form
  typedef union packed {
    mem_form_t m;
    ctl_form_t c;
  } instr_t;

endpackage

// File: hdl/dispatch_pkg.sv
package dispatch_pkg;

  // address and data widths of the cluster
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // cpu slots and slot index width
  localparam int NUM_SLOTS = 4;
  localparam int SLOT_W = 2;

  // run queue depth, a power of two
  localparam int RUNQ_DEPTH = 8;
  localparam int RUNQ_AW = 3;

  // fork request from a slot, start address of the child thread
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fork_msg_t;

  // round-robin pick, searching from index first upward with wrap
  // returns first when no bit of req is set
  function automatic logic [SLOT_W-1:0] rr_pick(
    input logic [NUM_SLOTS-1:0] req,
    input logic [SLOT_W-1:0] first
  );
    logic [SLOT_W-1:0] idx;
    logic [SLOT_W-1:0] pick;
    logic found;
    pick = first;
    found = 1'b0;
    for (int k = 0; k < NUM_SLOTS; k++) begin
      // index wraps by width
      idx = first + SLOT_W'(k);
      if (!found && req[idx]) begin
        pick = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

endpackage
